// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide by the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module axi_read_master_tb -f verilog.f -o axi_read_master_sim \
  && ./obj_dir/axi_read_master_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF '>>> PASS' sim.log && exit 0 || exit 1

// File: source/ar_burst_issuer.sv
`default_nettype none

module ar_burst_issuer import axi_read_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  burst_plan_t plan,
  input  logic        plan_load,
  input  logic        burst_drained,
  output logic        arvalid,
  input  logic        arready,
  output ar_req_t     ar
);

  logic                         ar_idle;
  logic [TXN_CNT_WIDTH-1:0]     txn_to_go;
  logic [ADDR_WIDTH-1:0]        next_addr;
  logic [LOG_BURST_LEN-1:0]     final_len_r;
  logic [OUTSTANDING_WIDTH-1:0] vacancy;
  logic                         ar_xfer;
  logic                         final_txn;
  logic                         stall;

  assign ar_xfer   = arvalid & arready;
  assign final_txn = (txn_to_go == '0);
  // No room left for another burst
  assign stall     = (vacancy == '0);

  ////////////////////
  // AR valid
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (!ar_idle && !stall && !arvalid) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  // Idle until a plan arrives, idle again after the final burst goes out
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (plan_load) begin
      ar_idle <= 1'b0;
    end else if (ar_xfer && final_txn) begin
      ar_idle <= 1'b1;
    end
  end

  // Bursts still to issue
  always_ff @(posedge aclk) begin
    if (areset) begin
      txn_to_go <= '0;
    end else if (plan_load) begin
      txn_to_go <= plan.last_txn_index;
    end else if (ar_xfer && !final_txn) begin
      txn_to_go <= txn_to_go - 1'b1;
    end
  end

  // Address walks up one burst per acceptance
  always_ff @(posedge aclk) begin
    if (plan_load) begin
      next_addr   <= plan.base_addr;
      final_len_r <= plan.final_len;
    end else if (ar_xfer) begin
      next_addr <= next_addr + ADDR_WIDTH'(BURST_BYTES);
    end
  end

  ////////////////////
  // Vacancy
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= OUTSTANDING_WIDTH'(MAX_OUTSTANDING);
    end else if (ar_xfer && !burst_drained) begin
      vacancy <= vacancy - 1'b1;
    end else if (burst_drained && !ar_xfer) begin
      vacancy <= vacancy + 1'b1;
    end
  end

  assign ar.addr = next_addr;
  // Short length only on the last burst
  assign ar.len  = final_txn ? 8'(final_len_r) : 8'(BURST_LEN - 1);

endmodule

`default_nettype wire

// File: source/axi_read_master.sv
`default_nettype none

module axi_read_master import axi_read_pkg::*; (
  input  logic      aclk,
  input  logic      areset,

  // Control
  input  logic      ctrl_start,
  input  xfer_cmd_t ctrl_cmd,
  output logic      ctrl_done,

  // AR channel
  output logic      arvalid,
  input  logic      arready,
  output ar_req_t   ar,

  // R channel
  input  logic      rvalid,
  output logic      rready,
  input  r_beat_t   r,

  // Stream out
  output logic      tvalid,
  input  logic      tready,
  output r_beat_t   t
);

  burst_plan_t plan;
  logic        plan_load;
  logic        burst_drained;

  ////////////////////
  // Command setup
  ////////////////////
  read_request_setup i_setup (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_cmd   (ctrl_cmd),
    .plan       (plan),
    .plan_load  (plan_load)
  );

  // Address side, paced by drained bursts
  ar_burst_issuer i_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .plan          (plan),
    .plan_load     (plan_load),
    .burst_drained (burst_drained),
    .arvalid       (arvalid),
    .arready       (arready),
    .ar            (ar)
  );

  // Done once every burst has returned on R
  r_completion_tracker i_tracker (
    .aclk      (aclk),
    .areset    (areset),
    .plan      (plan),
    .plan_load (plan_load),
    .rvalid    (rvalid),
    .rready    (rready),
    .r_last    (r.last),
    .ctrl_done (ctrl_done)
  );

  ////////////////////
  // Data path
  ////////////////////
  read_data_fifo i_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .rvalid        (rvalid),
    .r             (r),
    .rready        (rready),
    .tvalid        (tvalid),
    .tready        (tready),
    .t             (t),
    .burst_drained (burst_drained)
  );

endmodule

`default_nettype wire

// File: source/axi_read_pkg.sv
`default_nettype none

package axi_read_pkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int XFER_SIZE_WIDTH = 20;

  // Bytes per data beat
  localparam int DW_BYTES     = DATA_WIDTH / 8;
  localparam int LOG_DW_BYTES = $clog2(DW_BYTES);

  ////////////////////
  // Burst limits
  ////////////////////
  // Full burst stays inside one 4 KB page and under 256 beats
  localparam int BURST_LEN     = (4096 / DW_BYTES < 256) ? 4096 / DW_BYTES : 256;
  localparam int LOG_BURST_LEN = $clog2(BURST_LEN);
  localparam int BURST_BYTES   = BURST_LEN * DW_BYTES;

  localparam int MAX_OUTSTANDING   = 4;
  localparam int OUTSTANDING_WIDTH = $clog2(MAX_OUTSTANDING + 1);

  // Length in beats and burst index widths
  localparam int TOTAL_LEN_WIDTH = XFER_SIZE_WIDTH - LOG_DW_BYTES;
  localparam int TXN_CNT_WIDTH   = TOTAL_LEN_WIDTH - LOG_BURST_LEN;

  // Data FIFO holds every burst that may be in flight
  localparam int FIFO_DEPTH      = BURST_LEN * MAX_OUTSTANDING;
  localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

  ////////////////////
  // Shared structs
  ////////////////////
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      addr_offset;
    logic [XFER_SIZE_WIDTH-1:0] xfer_size;
  } xfer_cmd_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]    base_addr;
    logic [TXN_CNT_WIDTH-1:0] last_txn_index;  // Bursts minus one
    logic [LOG_BURST_LEN-1:0] final_len;       // Beats of last burst minus one
  } burst_plan_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;
  } ar_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } r_beat_t;

endpackage

`default_nettype wire

// File: source/r_completion_tracker.sv
`default_nettype none

module r_completion_tracker import axi_read_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  burst_plan_t plan,
  input  logic        plan_load,
  input  logic        rvalid,
  input  logic        rready,
  input  logic        r_last,
  output logic        ctrl_done
);

  logic [TXN_CNT_WIDTH-1:0] r_txn_to_go;
  logic                     burst_end;
  logic                     final_txn;

  // Last beat of any burst accepted
  assign burst_end = rvalid & rready & r_last;
  assign final_txn = (r_txn_to_go == '0);

  // Bursts left to complete on R
  always_ff @(posedge aclk) begin
    if (areset) begin
      r_txn_to_go <= '0;
    end else if (plan_load) begin
      r_txn_to_go <= plan.last_txn_index;
    end else if (burst_end && !final_txn) begin
      r_txn_to_go <= r_txn_to_go - 1'b1;
    end
  end

  // One cycle pulse after the final last beat
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= burst_end & final_txn;
    end
  end

endmodule

`default_nettype wire

// File: source/read_data_fifo.sv
`default_nettype none

module read_data_fifo import axi_read_pkg::*; (
  input  logic    aclk,
  input  logic    areset,
  input  logic    rvalid,
  input  r_beat_t r,
  output logic    rready,
  output logic    tvalid,
  input  logic    tready,
  output r_beat_t t,
  output logic    burst_drained
);

  r_beat_t                    mem [FIFO_DEPTH];
  logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
  logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
  logic [FIFO_ADDR_WIDTH:0]   count;
  logic                       push;
  logic                       pop;

  assign push = rvalid & rready;
  assign pop  = tvalid & tready;

  // Always ready once out of reset, the vacancy limit keeps room
  always_ff @(posedge aclk) begin
    if (areset) begin
      rready <= 1'b0;
    end else begin
      rready <= 1'b1;
    end
  end

  ////////////////////
  // Storage
  ////////////////////
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= r;
    end
  end

  // Pointers wrap naturally at the power of two depth
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////
  // Stream side
  ////////////////////
  // Head entry shown directly, first word fall-through
  assign tvalid        = (count != '0);
  assign t             = mem[rd_ptr];
  // A burst leaves the FIFO with its last beat
  assign burst_drained = pop & t.last;

endmodule

`default_nettype wire

// File: source/read_request_setup.sv
`default_nettype none

module read_request_setup import axi_read_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  logic        ctrl_start,
  input  xfer_cmd_t   ctrl_cmd,
  output burst_plan_t plan,
  output logic        plan_load
);

  // Whole beats in the request, arlen style
  logic [TOTAL_LEN_WIDTH-1:0] size_beats;
  logic                       size_has_tail;
  logic [TOTAL_LEN_WIDTH-1:0] total_len_r;
  logic [ADDR_WIDTH-1:0]      base_addr_r;
  logic [LOG_BURST_LEN-1:0]   final_len_r;
  logic                       start_d1;

  assign size_beats    = ctrl_cmd.xfer_size[LOG_DW_BYTES +: TOTAL_LEN_WIDTH];
  assign size_has_tail = |ctrl_cmd.xfer_size[0 +: LOG_DW_BYTES];

  ////////////////////
  // Command capture
  ////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // A partial word adds one beat, which cancels the minus one
      total_len_r <= size_has_tail ? size_beats : size_beats - 1'b1;
      // Align down to a burst boundary
      base_addr_r <= ctrl_cmd.addr_offset & ~ADDR_WIDTH'(BURST_BYTES - 1);
    end
  end

  // Two stage delay of the start strobe
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1  <= 1'b0;
      plan_load <= 1'b0;
    end else begin
      start_d1  <= ctrl_start;
      plan_load <= start_d1;
    end
  end

  // Beats in the final burst, taken one cycle after capture
  always_ff @(posedge aclk) begin
    final_len_r <= total_len_r[0 +: LOG_BURST_LEN];
  end

  // Upper length bits give the index of the last burst
  assign plan.base_addr      = base_addr_r;
  assign plan.last_txn_index = total_len_r[LOG_BURST_LEN +: TXN_CNT_WIDTH];
  assign plan.final_len      = final_len_r;

endmodule

`default_nettype wire

// File: tb/axi_read_master_assertions.sv
`default_nettype none

module axi_read_master_assertions import axi_read_pkg::*; (
  input logic    aclk,
  input logic    areset,
  input logic    arvalid,
  input logic    arready,
  input ar_req_t ar,
  input logic    ctrl_done
);

  ////////////////////
  // AR channel
  ////////////////////
  // A waiting request keeps valid and payload
  ar_held_until_ready: assert property (
    @(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(ar)
  ) else $error("AR request changed or dropped before arready");

  // Bursts start on a burst boundary
  ar_addr_aligned: assert property (
    @(posedge aclk) disable iff (areset)
    arvalid |-> (ar.addr & ADDR_WIDTH'(BURST_BYTES - 1)) == '0
  ) else $error("AR address not aligned to a burst boundary");

  ////////////////////
  // Control
  ////////////////////
  done_single_pulse: assert property (
    @(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done
  ) else $error("ctrl_done high for two cycles in a row");

endmodule

bind axi_read_master axi_read_master_assertions i_assertions (
  .aclk      (aclk),
  .areset    (areset),
  .arvalid   (arvalid),
  .arready   (arready),
  .ar        (ar),
  .ctrl_done (ctrl_done)
);

`default_nettype wire

// File: tb/axi_read_master_tb.sv
`default_nettype none

module axi_read_master_tb import axi_read_pkg::*; ();

  // Beats over all commands, sets the hang limit
  localparam int TOTAL_BEATS = 25 + 18 + 750 + 1500 + 500 + 128 + 9;
  localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 2000;

  logic      aclk    = 1'b0;
  logic      areset;
  logic      ctrl_start;
  xfer_cmd_t ctrl_cmd;
  logic      ctrl_done;
  logic      arvalid;
  logic      arready = 1'b0;
  ar_req_t   ar;
  logic      rvalid  = 1'b0;
  logic      rready;
  r_beat_t   r       = '0;
  logic      tvalid;
  logic      tready  = 1'b0;
  r_beat_t   t;

  // Slave model state
  logic [ADDR_WIDTH-1:0] ar_addr_q[$];
  logic [7:0]            ar_len_q[$];
  logic [7:0]            slave_beat = '0;
  logic                  r_accepted;

  // Current command and its expectations
  string       test_name;
  logic [31:0] exp_base;
  int          exp_beats;
  int          exp_bursts;
  int          cmd_beat_base;
  int          cmd_ar_base;
  int          cmd_done_base;
  int          cmd_rx_base;
  int          tready_mode = 0;  // 0 always ready, 1 random, 2 held low

  // Totals kept by the compare process
  int          beat_total  = 0;
  int          ar_total    = 0;
  int          done_total  = 0;
  int          rx_total    = 0;
  int          outstanding = 0;
  int          cycle_cnt   = 0;
  int          beat_idx;
  int          burst_idx;
  r_beat_t     exp_beat;

  axi_read_master i_dut (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_cmd   (ctrl_cmd),
    .ctrl_done  (ctrl_done),
    .arvalid    (arvalid),
    .arready    (arready),
    .ar         (ar),
    .rvalid     (rvalid),
    .rready     (rready),
    .r          (r),
    .tvalid     (tvalid),
    .tready     (tready),
    .t          (t)
  );

  always #10 aclk = ~aclk;

  ////////////////////
  // Reference model
  ////////////////////
  // Odd multiplier, so every byte address gives its own word
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A3C_96E1;
  endfunction

  // Beat idx of a read that starts at the aligned base
  function automatic r_beat_t expected_beat(input logic [31:0] base, input int idx,
                                            input int beats);
    r_beat_t beat;
    beat.data = mem_word(base + 32'(idx) * 32'd4);
    // Full bursts are 256 beats; the final beat closes the last one
    beat.last = ((idx + 1) % 256 == 0) || (idx == beats - 1);
    return beat;
  endfunction

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      end_with_failure($sformatf("CHECK FAILED %s %s expected 0x%08h actual 0x%08h",
                                 test_name, what, expected, actual));
    end
  endtask

  task automatic step_cycle();
    @(posedge aclk);
    #2;
  endtask

  // Strobe one command, remember what it should produce
  task automatic start_command(input string name, input logic [31:0] addr, input int size);
    test_name            = name;
    exp_base             = addr & ~32'h0000_03FF;
    exp_beats            = (size + 3) / 4;
    exp_bursts           = (exp_beats + 255) / 256;
    cmd_beat_base        = beat_total;
    cmd_ar_base          = ar_total;
    cmd_done_base        = done_total;
    cmd_rx_base          = rx_total;
    ctrl_cmd.addr_offset = addr;
    ctrl_cmd.xfer_size   = XFER_SIZE_WIDTH'(size);
    ctrl_start           = 1'b1;
    step_cycle();
    ctrl_start = 1'b0;
  endtask

  // Done seen and every beat streamed out
  task automatic wait_command();
    while (done_total == cmd_done_base || beat_total - cmd_beat_base < exp_beats) begin
      step_cycle();
    end
    check_value("ctrl_done_count", 32'd1, 32'(done_total - cmd_done_base));
    check_value("ar_count", 32'(exp_bursts), 32'(ar_total - cmd_ar_base));
  endtask

  ////////////////////
  // Memory slave
  ////////////////////
  always @(posedge aclk) begin
    if (arvalid && arready) begin
      ar_addr_q.push_back(ar.addr);
      ar_len_q.push_back(ar.len);
    end
    r_accepted = rvalid && rready;
    if (r_accepted) begin
      if (r.last) begin
        void'(ar_addr_q.pop_front());
        void'(ar_len_q.pop_front());
        slave_beat = '0;
      end else begin
        slave_beat++;
      end
    end
    #2;
    arready = ($urandom % 3) != 0;
    // An offered beat stays until taken
    if (!rvalid || r_accepted) begin
      if (ar_addr_q.size() > 0 && ($urandom % 4) != 0) begin
        rvalid = 1'b1;
        r.data = mem_word(ar_addr_q[0] + 32'(slave_beat) * 32'd4);
        r.last = (slave_beat == ar_len_q[0]);
      end else begin
        rvalid = 1'b0;
      end
    end
    case (tready_mode)
      1:       tready = ($urandom % 2) == 0;
      2:       tready = 1'b0;
      default: tready = 1'b1;
    endcase
  end

  ////////////////////
  // Compare
  ////////////////////
  always @(posedge aclk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      end_with_failure($sformatf("Timeout after %0d cycles, the read never finished",
                                 cycle_cnt));
    end
    if (!areset) begin
      if (arvalid && arready) begin
        burst_idx = ar_total - cmd_ar_base;
        if (burst_idx >= exp_bursts) begin
          end_with_failure("AR request issued past the end of the command");
        end
        check_value("ar_addr", exp_base + 32'(burst_idx) * 32'd1024, ar.addr);
        check_value("ar_len", 32'((burst_idx == exp_bursts - 1) ? (exp_beats - 1) % 256 : 255),
                    32'(ar.len));
        ar_total++;
        outstanding++;
        if (outstanding > 4) begin
          end_with_failure("More than four bursts in flight at once");
        end
      end
      if (tvalid && tready) begin
        beat_idx = beat_total - cmd_beat_base;
        if (beat_idx >= exp_beats) begin
          end_with_failure("Stream beat arrived after the end of the command");
        end
        exp_beat = expected_beat(exp_base, beat_idx, exp_beats);
        check_value("t_data", exp_beat.data, t.data);
        check_value("t_last", 32'(exp_beat.last), 32'(t.last));
        beat_total++;
        // A drained burst frees one slot
        if (t.last) begin
          outstanding--;
        end
      end
      // R is never back-pressured
      if (rvalid) begin
        check_value("rready", 32'd1, 32'(rready));
      end
      // Done only once every R beat of the command is in
      if (ctrl_done) begin
        check_value("r_beats_at_done", 32'(exp_beats), 32'(rx_total - cmd_rx_base));
        done_total++;
      end
      if (rvalid && rready) begin
        rx_total++;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    void'($urandom(86438));
    areset     = 1'b1;
    ctrl_start = 1'b0;
    ctrl_cmd   = '0;
    repeat (5) @(posedge aclk);
    #2;
    areset    = 1'b0;
    test_name = "reset";
    check_value("ctrl_done", 32'd0, 32'(ctrl_done));

    start_command("single_burst", 32'h0000_2000, 100);
    wait_command();
    // Low address bits drop to the burst boundary
    start_command("unaligned_start", 32'h0000_3123, 70);
    wait_command();
    start_command("three_bursts", 32'h0000_8000, 3000);
    wait_command();

    // Stream held off, AR must stop after four bursts
    tready_mode = 2;
    start_command("outstanding_cap", 32'h0001_0000, 6000);
    while (rx_total - cmd_rx_base < 1024) begin
      step_cycle();
    end
    repeat (50) step_cycle();
    check_value("ar_while_stalled", 32'd4, 32'(ar_total - cmd_ar_base));
    tready_mode = 0;
    wait_command();

    tready_mode = 1;
    start_command("random_stalls", 32'h0002_0404, 2000);
    wait_command();

    // Second start right after the first completes
    tready_mode = 0;
    start_command("back_to_back_a", 32'h0004_0000, 512);
    wait_command();
    start_command("back_to_back_b", 32'h0004_1FF8, 36);
    wait_command();

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
source/axi_read_pkg.sv
source/read_request_setup.sv
source/ar_burst_issuer.sv
source/r_completion_tracker.sv
source/read_data_fifo.sv
source/axi_read_master.sv
tb/axi_read_master_assertions.sv
tb/axi_read_master_tb.sv
